// File: include/decode_defines.svh
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// queue depths.
`define INST_QUEUE_DEPTH 4
`define RESULT_QUEUE_DEPTH 4

// register bus.
`define AXIL_ADDR_WIDTH 4
`define AXIL_DATA_WIDTH 32
`define AXIL_STRB_WIDTH 4

// byte offsets.
`define REG_INSTR 4'h0
`define REG_STATUS 4'h4
`define REG_RESULT 4'h8
`define REG_IMM 4'hC

`endif

// File: hw/riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

	typedef logic [31:0] inst_word_t;

	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;
	localparam logic [6:0] OP_JAL = 7'b1101111;
	localparam logic [6:0] OP_JALR = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_IMM_32 = 7'b0011011;
	localparam logic [6:0] OP_REG = 7'b0110011;
	localparam logic [6:0] OP_REG_32 = 7'b0111011;
	localparam logic [6:0] OP_MISC_MEM = 7'b0001111;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT = 7'b0100000;   // sub and arithmetic shifts.
	localparam logic [6:0] F7_MULDIV = 7'b0000001;

	localparam logic [31:0] INST_ECALL = 32'h00000073;
	localparam logic [31:0] INST_EBREAK = 32'h00100073;

	typedef enum logic [6:0] {
		UNKNOWN = 7'd0,
		LUI, AUIPC, JAL, JALR,
		BEQ, BNE, BLT, BGE, BLTU, BGEU,
		LB, LH, LW, LD, LBU, LHU, LWU,
		SB, SH, SW, SD,
		ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
		ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
		ADDIW, SLLIW, SRLIW, SRAIW,
		ADDW, SUBW, SLLW, SRLW, SRAW,
		MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,
		MULW, DIVW, DIVUW, REMW, REMUW,
		FENCE, FENCE_I, ECALL, EBREAK
	} mnemonic_e;

	typedef enum logic [2:0] {
		FMT_R, FMT_I, FMT_S, FMT_SB, FMT_U, FMT_UJ, FMT_UNKNOWN
	} format_e;

	typedef struct packed {
		logic mem_operand;   // offset(base) operand.
		logic is_signed;
		logic is_load;
	} decode_flags_t;

	typedef struct packed {
		mnemonic_e mnemonic;
		format_e format;
		decode_flags_t flags;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [31:0] imm;
	} decoded_t;

endpackage

`default_nettype wire

// File: hw/axil_pkg.sv
`default_nettype none

`include "decode_defines.svh"

package axil_pkg;

	localparam logic [1:0] AXIL_OKAY = 2'b00;
	localparam logic [1:0] AXIL_SLVERR = 2'b10;

	typedef struct packed {
		logic [`AXIL_ADDR_WIDTH-1:0] addr;
	} axil_aw_t;

	typedef struct packed {
		logic [`AXIL_DATA_WIDTH-1:0] data;
		logic [`AXIL_STRB_WIDTH-1:0] strb;
	} axil_w_t;

	typedef struct packed {
		logic [1:0] resp;
	} axil_b_t;

	typedef struct packed {
		logic [`AXIL_ADDR_WIDTH-1:0] addr;
	} axil_ar_t;

	typedef struct packed {
		logic [`AXIL_DATA_WIDTH-1:0] data;
		logic [1:0] resp;
	} axil_r_t;

endpackage

`default_nettype wire

// File: hw/inst_classify.sv
`timescale 1ns/1ps
`default_nettype none

module inst_classify
	import riscv_isa_pkg::*;
(
	input  inst_word_t    inst,
	output mnemonic_e     mnemonic,
	output format_e       format,
	output decode_flags_t flags
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	always_comb
	begin
		mnemonic = UNKNOWN;
		format = FMT_UNKNOWN;
		case (opcode)
			OP_LUI:
			begin
				mnemonic = LUI;
				format = FMT_U;
			end
			OP_AUIPC:
			begin
				mnemonic = AUIPC;
				format = FMT_U;
			end
			OP_JAL:
			begin
				mnemonic = JAL;
				format = FMT_UJ;
			end
			OP_JALR:
			begin
				format = FMT_I;
				if (funct3 == 3'b000)
					mnemonic = JALR;
			end
			OP_BRANCH:
			begin
				format = FMT_SB;
				case (funct3)
					3'b000: mnemonic = BEQ;
					3'b001: mnemonic = BNE;
					3'b100: mnemonic = BLT;
					3'b101: mnemonic = BGE;
					3'b110: mnemonic = BLTU;
					3'b111: mnemonic = BGEU;
					default: mnemonic = UNKNOWN;
				endcase
			end
			OP_LOAD:
			begin
				format = FMT_I;
				case (funct3)
					3'b000: mnemonic = LB;
					3'b001: mnemonic = LH;
					3'b010: mnemonic = LW;
					3'b011: mnemonic = LD;
					3'b100: mnemonic = LBU;
					3'b101: mnemonic = LHU;
					3'b110: mnemonic = LWU;
					default: mnemonic = UNKNOWN;
				endcase
			end
			OP_STORE:
			begin
				format = FMT_S;
				case (funct3)
					3'b000: mnemonic = SB;
					3'b001: mnemonic = SH;
					3'b010: mnemonic = SW;
					3'b011: mnemonic = SD;
					default: mnemonic = UNKNOWN;
				endcase
			end
			OP_IMM:
			begin
				format = FMT_I;
				case (funct3)
					3'b000: mnemonic = ADDI;
					3'b010: mnemonic = SLTI;
					3'b011: mnemonic = SLTIU;
					3'b100: mnemonic = XORI;
					3'b110: mnemonic = ORI;
					3'b111: mnemonic = ANDI;
					3'b001:
						if (funct7[6:1] == F7_BASE[6:1])   // shamt[5] sits in bit 25.
							mnemonic = SLLI;
					default:
						if (funct7[6:1] == F7_BASE[6:1])
							mnemonic = SRLI;
						else if (funct7[6:1] == F7_ALT[6:1])
							mnemonic = SRAI;
				endcase
			end
			OP_IMM_32:
			begin
				format = FMT_I;
				case ({funct7, funct3})
					{F7_BASE, 3'b001}: mnemonic = SLLIW;
					{F7_BASE, 3'b101}: mnemonic = SRLIW;
					{F7_ALT, 3'b101}: mnemonic = SRAIW;
					default:
						if (funct3 == 3'b000)
							mnemonic = ADDIW;
				endcase
			end
			OP_REG:
			begin
				format = FMT_R;
				case ({funct7, funct3})
					{F7_BASE, 3'b000}: mnemonic = ADD;
					{F7_ALT, 3'b000}: mnemonic = SUB;
					{F7_BASE, 3'b001}: mnemonic = SLL;
					{F7_BASE, 3'b010}: mnemonic = SLT;
					{F7_BASE, 3'b011}: mnemonic = SLTU;
					{F7_BASE, 3'b100}: mnemonic = XOR;
					{F7_BASE, 3'b101}: mnemonic = SRL;
					{F7_ALT, 3'b101}: mnemonic = SRA;
					{F7_BASE, 3'b110}: mnemonic = OR;
					{F7_BASE, 3'b111}: mnemonic = AND;
					{F7_MULDIV, 3'b000}: mnemonic = MUL;
					{F7_MULDIV, 3'b001}: mnemonic = MULH;
					{F7_MULDIV, 3'b010}: mnemonic = MULHSU;
					{F7_MULDIV, 3'b011}: mnemonic = MULHU;
					{F7_MULDIV, 3'b100}: mnemonic = DIV;
					{F7_MULDIV, 3'b101}: mnemonic = DIVU;
					{F7_MULDIV, 3'b110}: mnemonic = REM;
					{F7_MULDIV, 3'b111}: mnemonic = REMU;
					default: mnemonic = UNKNOWN;
				endcase
			end
			OP_REG_32:
			begin
				format = FMT_R;
				case ({funct7, funct3})
					{F7_BASE, 3'b000}: mnemonic = ADDW;
					{F7_ALT, 3'b000}: mnemonic = SUBW;
					{F7_BASE, 3'b001}: mnemonic = SLLW;
					{F7_BASE, 3'b101}: mnemonic = SRLW;
					{F7_ALT, 3'b101}: mnemonic = SRAW;
					{F7_MULDIV, 3'b000}: mnemonic = MULW;
					{F7_MULDIV, 3'b100}: mnemonic = DIVW;
					{F7_MULDIV, 3'b101}: mnemonic = DIVUW;
					{F7_MULDIV, 3'b110}: mnemonic = REMW;
					{F7_MULDIV, 3'b111}: mnemonic = REMUW;
					default: mnemonic = UNKNOWN;
				endcase
			end
			OP_MISC_MEM:
				if (funct3 == 3'b000)
					mnemonic = FENCE;
				else if (funct3 == 3'b001)
					mnemonic = FENCE_I;
			OP_SYSTEM:
				if (inst == INST_ECALL)
					mnemonic = ECALL;
				else if (inst == INST_EBREAK)
					mnemonic = EBREAK;   // csr accesses stay unknown.
			default: mnemonic = UNKNOWN;
		endcase
		if (mnemonic == UNKNOWN)
			format = FMT_UNKNOWN;
	end

	assign flags.is_load = mnemonic inside {LB, LH, LW, LD, LBU, LHU, LWU};
	assign flags.mem_operand = flags.is_load || (mnemonic inside {SB, SH, SW, SD});
	assign flags.is_signed = !(mnemonic inside {BLTU, BGEU, LBU, LHU, LWU, SLTIU, SLTU, ORI});

endmodule

`default_nettype wire

// File: hw/operand_extract.sv
`timescale 1ns/1ps
`default_nettype none

module operand_extract
	import riscv_isa_pkg::*;
(
	input  inst_word_t  inst,
	input  format_e     format,
	output logic [4:0]  rd,
	output logic [4:0]  rs1,
	output logic [4:0]  rs2,
	output logic [31:0] imm
);

	logic shamt_d;
	logic shamt_w;

	// funct3 001 and 101 only.
	assign shamt_d = inst[6:0] == OP_IMM && inst[13:12] == 2'b01;
	assign shamt_w = inst[6:0] == OP_IMM_32 && inst[13:12] == 2'b01;

	always_comb
	begin
		rd = 5'd0;
		rs1 = 5'd0;
		rs2 = 5'd0;
		imm = 32'd0;
		case (format)
			FMT_R:
			begin
				rd = inst[11:7];
				rs1 = inst[19:15];
				rs2 = inst[24:20];
			end
			FMT_I:
			begin
				rd = inst[11:7];
				rs1 = inst[19:15];
				if (shamt_d)
					imm = {26'd0, inst[25:20]};
				else if (shamt_w)
					imm = {27'd0, inst[24:20]};
				else
					imm = {{20{inst[31]}}, inst[31:20]};
			end
			FMT_S:
			begin
				rs1 = inst[19:15];
				rs2 = inst[24:20];
				imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			end
			FMT_SB:
			begin
				rs1 = inst[19:15];
				rs2 = inst[24:20];
				imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			end
			FMT_U:
			begin
				rd = inst[11:7];
				imm = {inst[31:12], 12'd0};
			end
			FMT_UJ:
			begin
				rd = inst[11:7];
				imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			default: imm = 32'd0;   // unknown words carry no operands.
		endcase
	end

endmodule

`default_nettype wire

// File: hw/decode_queue.sv
`timescale 1ns/1ps
`default_nettype none

module decode_queue #(
	parameter type T = logic [31:0],
	parameter int DEPTH = 4
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  T                             din,
	input  logic                         push,
	output logic                         full,
	output T                             dout,
	input  logic                         pop,
	output logic                         empty,
	output logic [$clog2(DEPTH+1)-1:0]   count
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T mem [0:DEPTH-1];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full = count == CNT_W'(DEPTH);
	assign empty = count == '0;
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;   // idle or push with pop.
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) full |-> !push)
		else $error("decode_queue push while full");
	assert property (@(posedge clk) disable iff (!rst_n) empty |-> !pop)
		else $error("decode_queue pop while empty");

endmodule

`default_nettype wire

// File: hw/axil_decode_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module axil_decode_regs
	import riscv_isa_pkg::*, axil_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  axil_aw_t   aw,
	input  logic       awvalid,
	output logic       awready,
	input  axil_w_t    w,
	input  logic       wvalid,
	output logic       wready,
	output axil_b_t    b,
	output logic       bvalid,
	input  logic       bready,
	input  axil_ar_t   ar,
	input  logic       arvalid,
	output logic       arready,
	output axil_r_t    r,
	output logic       rvalid,
	input  logic       rready,
	output inst_word_t inst,
	output logic       inst_push,
	input  logic       inst_full,
	input  decoded_t   result,
	input  logic       result_empty,
	input  logic [2:0] result_count,
	output logic       result_pop
);

	axil_aw_t aw_q;
	axil_w_t w_q;
	logic aw_held;
	logic w_held;
	axil_aw_t aw_cur;
	axil_w_t w_cur;
	logic wr_go;
	logic wr_ok;
	logic rd_go;
	axil_r_t rd_resp;

	// each channel is taken once and parked until its partner arrives.
	assign awready = !bvalid && !aw_held;
	assign wready = !bvalid && !w_held;
	assign arready = !rvalid;
	assign aw_cur = aw_held ? aw_q : aw;
	assign w_cur = w_held ? w_q : w;
	assign wr_go = (aw_held || awvalid) && (w_held || wvalid) && !bvalid;
	assign wr_ok = aw_cur.addr == `REG_INSTR && w_cur.strb == 4'hf && !inst_full;
	assign inst = w_cur.data;
	assign inst_push = wr_go && wr_ok;
	assign rd_go = arvalid && arready;
	assign result_pop = rd_go && ar.addr == `REG_IMM && !result_empty;

	always_comb
	begin
		rd_resp = '{data: 32'd0, resp: AXIL_SLVERR};
		case (ar.addr)
			`REG_STATUS:
				rd_resp = '{data: {21'd0, result_count, 6'd0, inst_full, !result_empty},
					resp: AXIL_OKAY};
			`REG_RESULT:
				if (!result_empty)
					rd_resp = '{data: {4'd0, result.mnemonic, result.format, result.flags,
						result.rd, result.rs1, result.rs2}, resp: AXIL_OKAY};
			`REG_IMM:
				if (!result_empty)
					rd_resp = '{data: result.imm, resp: AXIL_OKAY};
			default: rd_resp = '{data: 32'd0, resp: AXIL_SLVERR};
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (awvalid && awready)
			aw_q <= aw;
		if (wvalid && wready)
			w_q <= w;
		if (wr_go)
			b <= '{resp: wr_ok ? AXIL_OKAY : AXIL_SLVERR};
		if (rd_go)
			r <= rd_resp;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			aw_held <= 1'b0;
			w_held <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			if (wr_go)
			begin
				aw_held <= 1'b0;
				w_held <= 1'b0;
				bvalid <= 1'b1;
			end
			else
			begin
				if (awvalid && awready)
					aw_held <= 1'b1;
				if (wvalid && wready)
					w_held <= 1'b1;
				if (bvalid && bready)
					bvalid <= 1'b0;
			end
			if (rd_go)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) bvalid && !bready |=> bvalid && $stable(b))
		else $error("b dropped or changed before bready");
	assert property (@(posedge clk) disable iff (!rst_n) rvalid && !rready |=> rvalid && $stable(r))
		else $error("r dropped or changed before rready");

endmodule

`default_nettype wire

// File: hw/decode_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module decode_top
	import riscv_isa_pkg::*, axil_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  axil_aw_t aw,
	input  logic     awvalid,
	output logic     awready,
	input  axil_w_t  w,
	input  logic     wvalid,
	output logic     wready,
	output axil_b_t  b,
	output logic     bvalid,
	input  logic     bready,
	input  axil_ar_t ar,
	input  logic     arvalid,
	output logic     arready,
	output axil_r_t  r,
	output logic     rvalid,
	input  logic     rready
);

	inst_word_t wr_word;
	inst_word_t head_word;
	logic inst_push;
	logic inst_full;
	logic inst_empty;
	decoded_t decoded;
	decoded_t result_head;
	logic result_full;
	logic result_empty;
	logic result_pop;
	logic [2:0] result_count;
	mnemonic_e mnemonic;
	format_e format;
	decode_flags_t flags;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [31:0] imm;
	logic xfer;

	// one word moves per clock when both sides allow it.
	assign xfer = !inst_empty && !result_full;
	assign decoded = '{mnemonic: mnemonic, format: format, flags: flags,
		rd: rd, rs1: rs1, rs2: rs2, imm: imm};

	axil_decode_regs u_regs (
		.clk(clk), .rst_n(rst_n),
		.aw(aw), .awvalid(awvalid), .awready(awready),
		.w(w), .wvalid(wvalid), .wready(wready),
		.b(b), .bvalid(bvalid), .bready(bready),
		.ar(ar), .arvalid(arvalid), .arready(arready),
		.r(r), .rvalid(rvalid), .rready(rready),
		.inst(wr_word), .inst_push(inst_push), .inst_full(inst_full),
		.result(result_head), .result_empty(result_empty),
		.result_count(result_count), .result_pop(result_pop)
	);

	decode_queue #(.T(inst_word_t), .DEPTH(`INST_QUEUE_DEPTH)) u_inst_queue (
		.clk(clk), .rst_n(rst_n),
		.din(wr_word), .push(inst_push), .full(inst_full),
		.dout(head_word), .pop(xfer), .empty(inst_empty), .count()
	);

	inst_classify u_classify (
		.inst(head_word), .mnemonic(mnemonic), .format(format), .flags(flags)
	);

	operand_extract u_extract (
		.inst(head_word), .format(format), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm)
	);

	decode_queue #(.T(decoded_t), .DEPTH(`RESULT_QUEUE_DEPTH)) u_result_queue (
		.clk(clk), .rst_n(rst_n),
		.din(decoded), .push(xfer), .full(result_full),
		.dout(result_head), .pop(result_pop), .empty(result_empty), .count(result_count)
	);

endmodule

`default_nettype wire

// File: bench/decode_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module decode_tb
	import riscv_isa_pkg::*, axil_pkg::*;
();

	localparam int RESULT_DEPTH = `RESULT_QUEUE_DEPTH;
	localparam int HELD_MAX = `INST_QUEUE_DEPTH + `RESULT_QUEUE_DEPTH;
	localparam int RESET_CYCLES = 16;
	localparam int CYCLES_PER_TXN = 200;
	localparam int N_FIXED = 29;

	// one word per format, flag mix and unknown class.
	localparam logic [31:0] FIXED_WORDS [0:N_FIXED-1] = '{
		32'h002081b3, 32'h407302b3, 32'h02c58533, 32'h005231b3, 32'h003100bb,
		32'h0231d0bb, 32'hfff10093, 32'h00513093, 32'h80016093, 32'h02131293,
		32'h43f45393, 32'h41f1509b, 32'hff813203, 32'h0043c303, 32'hfe513823,
		32'hfe20eee3, 32'h0020f463, 32'hfffff2b7, 32'h12345097, 32'h8000006f,
		32'h00c280e7, 32'h0ff0000f, 32'h0000100f, 32'h00000073, 32'h00100073,
		32'h00002007, 32'h30529073, 32'hffffffff, 32'h00004501
	};

	localparam logic [6:0] OPCODES [0:12] = '{
		7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03, 7'h23,
		7'h13, 7'h1b, 7'h33, 7'h3b, 7'h0f, 7'h73
	};

	logic clk = 1'b0;
	logic rst_n;
	axil_aw_t aw;
	logic awvalid;
	logic awready;
	axil_w_t w;
	logic wvalid;
	logic wready;
	axil_b_t b;
	logic bvalid;
	logic bready;
	axil_ar_t ar;
	logic arvalid;
	logic arready;
	axil_r_t r;
	logic rvalid;
	logic rready;

	decoded_t sb [$];   // accepted words, oldest first.
	axil_r_t exp_r;
	logic [1:0] exp_b;
	int errors;
	int n_reads;
	int n_writes;
	int txn_count;
	int cycles;
	int stall_max;
	int unsigned seed_val;

	decode_top dut (
		.clk(clk), .rst_n(rst_n),
		.aw(aw), .awvalid(awvalid), .awready(awready),
		.w(w), .wvalid(wvalid), .wready(wready),
		.b(b), .bvalid(bvalid), .bready(bready),
		.ar(ar), .arvalid(arvalid), .arready(arready),
		.r(r), .rvalid(rvalid), .rready(rready)
	);

	always #10 clk = ~clk;

	function automatic decoded_t decode_expected(input inst_word_t word);
		decoded_t d;
		logic [6:0] op;
		logic [2:0] f3;
		logic [6:0] f7;
		logic signed [11:0] i_off;
		logic signed [11:0] s_off;
		logic signed [12:0] b_off;
		logic signed [20:0] j_off;
		op = word[6:0];
		f3 = word[14:12];
		f7 = word[31:25];
		d = '0;
		d.mnemonic = UNKNOWN;
		case (op)
			7'h37: d.mnemonic = LUI;
			7'h17: d.mnemonic = AUIPC;
			7'h6f: d.mnemonic = JAL;
			7'h67: d.mnemonic = (f3 == 3'd0) ? JALR : UNKNOWN;
			7'h63:
				case (f3)
					3'd0: d.mnemonic = BEQ;
					3'd1: d.mnemonic = BNE;
					3'd4: d.mnemonic = BLT;
					3'd5: d.mnemonic = BGE;
					3'd6: d.mnemonic = BLTU;
					3'd7: d.mnemonic = BGEU;
					default: d.mnemonic = UNKNOWN;
				endcase
			7'h03:
				case (f3)
					3'd0: d.mnemonic = LB;
					3'd1: d.mnemonic = LH;
					3'd2: d.mnemonic = LW;
					3'd3: d.mnemonic = LD;
					3'd4: d.mnemonic = LBU;
					3'd5: d.mnemonic = LHU;
					3'd6: d.mnemonic = LWU;
					default: d.mnemonic = UNKNOWN;
				endcase
			7'h23:
				case (f3)
					3'd0: d.mnemonic = SB;
					3'd1: d.mnemonic = SH;
					3'd2: d.mnemonic = SW;
					3'd3: d.mnemonic = SD;
					default: d.mnemonic = UNKNOWN;
				endcase
			7'h13:
				case (f3)
					3'd0: d.mnemonic = ADDI;
					3'd1: d.mnemonic = (word[31:26] == 6'h00) ? SLLI : UNKNOWN;
					3'd2: d.mnemonic = SLTI;
					3'd3: d.mnemonic = SLTIU;
					3'd4: d.mnemonic = XORI;
					3'd5:
						if (word[31:26] == 6'h00)
							d.mnemonic = SRLI;
						else if (word[31:26] == 6'h10)
							d.mnemonic = SRAI;
					3'd6: d.mnemonic = ORI;
					default: d.mnemonic = ANDI;
				endcase
			7'h1b:
				if (f3 == 3'd0)
					d.mnemonic = ADDIW;
				else if (f3 == 3'd1 && f7 == 7'h00)
					d.mnemonic = SLLIW;
				else if (f3 == 3'd5 && f7 == 7'h00)
					d.mnemonic = SRLIW;
				else if (f3 == 3'd5 && f7 == 7'h20)
					d.mnemonic = SRAIW;
			7'h33:
				if (f7 == 7'h00)
				begin
					case (f3)
						3'd0: d.mnemonic = ADD;
						3'd1: d.mnemonic = SLL;
						3'd2: d.mnemonic = SLT;
						3'd3: d.mnemonic = SLTU;
						3'd4: d.mnemonic = XOR;
						3'd5: d.mnemonic = SRL;
						3'd6: d.mnemonic = OR;
						default: d.mnemonic = AND;
					endcase
				end
				else if (f7 == 7'h20 && f3 == 3'd0)
					d.mnemonic = SUB;
				else if (f7 == 7'h20 && f3 == 3'd5)
					d.mnemonic = SRA;
				else if (f7 == 7'h01)
				begin
					case (f3)
						3'd0: d.mnemonic = MUL;
						3'd1: d.mnemonic = MULH;
						3'd2: d.mnemonic = MULHSU;
						3'd3: d.mnemonic = MULHU;
						3'd4: d.mnemonic = DIV;
						3'd5: d.mnemonic = DIVU;
						3'd6: d.mnemonic = REM;
						default: d.mnemonic = REMU;
					endcase
				end
			7'h3b:
				if (f7 == 7'h00 && f3 == 3'd0)
					d.mnemonic = ADDW;
				else if (f7 == 7'h00 && f3 == 3'd1)
					d.mnemonic = SLLW;
				else if (f7 == 7'h00 && f3 == 3'd5)
					d.mnemonic = SRLW;
				else if (f7 == 7'h20 && f3 == 3'd0)
					d.mnemonic = SUBW;
				else if (f7 == 7'h20 && f3 == 3'd5)
					d.mnemonic = SRAW;
				else if (f7 == 7'h01)
				begin
					case (f3)
						3'd0: d.mnemonic = MULW;
						3'd4: d.mnemonic = DIVW;
						3'd5: d.mnemonic = DIVUW;
						3'd6: d.mnemonic = REMW;
						3'd7: d.mnemonic = REMUW;
						default: d.mnemonic = UNKNOWN;
					endcase
				end
			7'h0f: d.mnemonic = (f3 == 3'd0) ? FENCE : ((f3 == 3'd1) ? FENCE_I : UNKNOWN);
			7'h73:
				if (word == 32'h73)
					d.mnemonic = ECALL;
				else if (word == 32'h100073)
					d.mnemonic = EBREAK;
			default: d.mnemonic = UNKNOWN;
		endcase

		// fence and system words carry no format.
		d.format = FMT_UNKNOWN;
		if (d.mnemonic != UNKNOWN)
		begin
			case (op)
				7'h37, 7'h17: d.format = FMT_U;
				7'h6f: d.format = FMT_UJ;
				7'h67, 7'h03, 7'h13, 7'h1b: d.format = FMT_I;
				7'h63: d.format = FMT_SB;
				7'h23: d.format = FMT_S;
				7'h33, 7'h3b: d.format = FMT_R;
				default: d.format = FMT_UNKNOWN;
			endcase
		end

		d.flags.is_load = op == 7'h03 && d.mnemonic != UNKNOWN;
		d.flags.mem_operand = d.flags.is_load || (op == 7'h23 && d.mnemonic != UNKNOWN);
		case (d.mnemonic)
			BLTU, BGEU, LBU, LHU, LWU, SLTIU, SLTU, ORI: d.flags.is_signed = 1'b0;
			default: d.flags.is_signed = 1'b1;
		endcase

		i_off = word[31:20];
		s_off = {word[31:25], word[11:7]};
		b_off = {word[31], word[7], word[30:25], word[11:8], 1'b0};
		j_off = {word[31], word[19:12], word[20], word[30:21], 1'b0};
		case (d.format)
			FMT_R:
			begin
				d.rd = word[11:7];
				d.rs1 = word[19:15];
				d.rs2 = word[24:20];
			end
			FMT_I:
			begin
				d.rd = word[11:7];
				d.rs1 = word[19:15];
				if (d.mnemonic inside {SLLI, SRLI, SRAI})
					d.imm = {26'd0, word[25:20]};
				else if (d.mnemonic inside {SLLIW, SRLIW, SRAIW})
					d.imm = {27'd0, word[24:20]};
				else
					d.imm = 32'(i_off);
			end
			FMT_S:
			begin
				d.rs1 = word[19:15];
				d.rs2 = word[24:20];
				d.imm = 32'(s_off);
			end
			FMT_SB:
			begin
				d.rs1 = word[19:15];
				d.rs2 = word[24:20];
				d.imm = 32'(b_off);
			end
			FMT_U:
			begin
				d.rd = word[11:7];
				d.imm = {word[31:12], 12'd0};
			end
			FMT_UJ:
			begin
				d.rd = word[11:7];
				d.imm = 32'(j_off);
			end
			default: d.imm = 32'd0;
		endcase
		return d;
	endfunction

	function automatic logic [31:0] pack_result(input decoded_t d);
		return {4'd0, d.mnemonic, d.format, d.flags, d.rd, d.rs1, d.rs2};
	endfunction

	function automatic logic [31:0] status_expected();
		int held;
		int avail;
		held = sb.size();
		avail = (held > RESULT_DEPTH) ? RESULT_DEPTH : held;
		return {21'd0, 3'(avail), 6'd0, held >= HELD_MAX, avail != 0};
	endfunction

	function automatic inst_word_t random_word();
		logic [31:0] raw;
		raw = $urandom;
		if (raw[1:0] == 2'b00)
			return $urandom;   // fully random and mostly unknown.
		return {raw[31:7], OPCODES[$urandom % 13]};
	endfunction

	function automatic int pick_stall();
		if (stall_max == 0)
			return 0;
		return int'($urandom % (stall_max + 1));
	endfunction

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		logic aw_pend;
		logic w_pend;
		logic aw_take;
		logic w_take;
		int stall;
		txn_count++;
		if (addr == `REG_INSTR && strb == 4'hf && sb.size() < HELD_MAX)
		begin
			exp_b = AXIL_OKAY;
			sb.push_back(decode_expected(data));
		end
		else
			exp_b = AXIL_SLVERR;
		aw.addr = addr;
		w.data = data;
		w.strb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		aw_pend = 1'b1;
		w_pend = 1'b1;
		while (aw_pend || w_pend)
		begin
			aw_take = aw_pend && awready;
			w_take = w_pend && wready;
			@(negedge clk);
			if (aw_take)
			begin
				aw_pend = 1'b0;
				awvalid = 1'b0;
			end
			if (w_take)
			begin
				w_pend = 1'b0;
				wvalid = 1'b0;
			end
		end
		while (!bvalid)
			@(negedge clk);
		stall = pick_stall();
		repeat (stall) @(negedge clk);
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic read_reg(input logic [3:0] addr);
		int stall;
		txn_count++;
		exp_r = '{data: 32'd0, resp: AXIL_SLVERR};
		case (addr)
			`REG_STATUS: exp_r = '{data: status_expected(), resp: AXIL_OKAY};
			`REG_RESULT:
				if (sb.size() != 0)
					exp_r = '{data: pack_result(sb[0]), resp: AXIL_OKAY};
			`REG_IMM:
				if (sb.size() != 0)
				begin
					exp_r = '{data: sb[0].imm, resp: AXIL_OKAY};
					sb.delete(0);   // the imm read pops.
				end
			default: exp_r.resp = AXIL_SLVERR;
		endcase
		ar.addr = addr;
		arvalid = 1'b1;
		while (!arready)
			@(negedge clk);
		@(negedge clk);
		arvalid = 1'b0;
		while (!rvalid)
			@(negedge clk);
		stall = pick_stall();
		repeat (stall) @(negedge clk);
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic run_word(input inst_word_t word);
		write_reg(`REG_INSTR, word, 4'hf);
		read_reg(`REG_STATUS);
		read_reg(`REG_RESULT);
		read_reg(`REG_IMM);
	endtask

	assert property (@(posedge clk) $rose(rst_n) |->
		!bvalid && !rvalid && awready && wready && arready)
	else
	begin
		errors++;
		$display("bus outputs were not idle right after reset");
	end

	assert property (@(posedge clk) disable iff (!rst_n) bvalid |-> !awready && !wready)
	else
	begin
		errors++;
		$display("write channels were ready while a write response was pending");
	end

	assert property (@(posedge clk) disable iff (!rst_n) rvalid |-> !arready)
	else
	begin
		errors++;
		$display("read address channel was ready while a read response was pending");
	end

	assert property (@(posedge clk) disable iff (!rst_n) rvalid && rready |->
		r.data == exp_r.data)
	else
	begin
		errors++;
		$display("ERROR r.data expected %h actual %h", $sampled(exp_r.data), $sampled(r.data));
	end

	assert property (@(posedge clk) disable iff (!rst_n) rvalid && rready |->
		r.resp == exp_r.resp)
	else
	begin
		errors++;
		$display("ERROR r.resp expected %h actual %h", $sampled(exp_r.resp), $sampled(r.resp));
	end

	assert property (@(posedge clk) disable iff (!rst_n) bvalid && bready |-> b.resp == exp_b)
	else
	begin
		errors++;
		$display("ERROR b.resp expected %h actual %h", $sampled(exp_b), $sampled(b.resp));
	end

	assert property (@(posedge clk) disable iff (!rst_n) bvalid && !bready |=>
		bvalid && $stable(b))
	else
	begin
		errors++;
		$display("write response changed or dropped before it was accepted");
	end

	assert property (@(posedge clk) disable iff (!rst_n) rvalid && !rready |=>
		rvalid && $stable(r))
	else
	begin
		errors++;
		$display("read response changed or dropped before it was accepted");
	end

	always @(posedge clk)
	begin
		if (rst_n && rvalid && rready)
			n_reads++;
		if (rst_n && bvalid && bready)
			n_writes++;
	end

	// watchdog grows with every issued transaction.
	always @(posedge clk)
	begin
		cycles++;
		if (cycles > CYCLES_PER_TXN * (txn_count + 1) + RESET_CYCLES)
		begin
			$display("timeout: the DUT did not respond within %0d cycles", cycles);
			$display("reads %0d, writes %0d, errors %0d", n_reads, n_writes, errors);
			$display("Simulation failed");
			$finish;
		end
	end

	initial
	begin
		seed_val = $urandom(32'hcb8b);
		errors = 0;
		n_reads = 0;
		n_writes = 0;
		txn_count = 0;
		cycles = 0;
		stall_max = 0;
		rst_n = 1'b0;
		aw = '0;
		awvalid = 1'b0;
		w = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		ar = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		exp_r = '0;
		exp_b = AXIL_OKAY;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		read_reg(`REG_STATUS);
		read_reg(`REG_IMM);
		read_reg(`REG_RESULT);
		for (int i = 0; i < N_FIXED; i++)
			run_word(FIXED_WORDS[i]);

		repeat (2)
		begin
			for (int i = 0; i < 4; i++)
			begin
				write_reg(`REG_INSTR, random_word(), 4'hf);
				read_reg(`REG_STATUS);
			end
			for (int i = 0; i < 4; i++)
			begin
				read_reg(`REG_RESULT);
				read_reg(`REG_IMM);
				read_reg(`REG_STATUS);
			end
		end

		// both queues full, then one more word.
		for (int i = 0; i < HELD_MAX; i++)
		begin
			write_reg(`REG_INSTR, random_word(), 4'hf);
			read_reg(`REG_STATUS);
		end
		write_reg(`REG_INSTR, random_word(), 4'hf);
		write_reg(`REG_STATUS, 32'h1, 4'hf);
		for (int i = 0; i < HELD_MAX; i++)
		begin
			read_reg(`REG_RESULT);
			read_reg(`REG_IMM);
			read_reg(`REG_STATUS);
		end
		read_reg(`REG_IMM);
		read_reg(`REG_RESULT);
		write_reg(`REG_INSTR, 32'h002081b3, 4'h3);
		write_reg(`REG_STATUS, 32'h0, 4'hf);

		stall_max = 7;
		repeat (3)
		begin
			for (int i = 0; i < 6; i++)
			begin
				write_reg(`REG_INSTR, random_word(), 4'hf);
				read_reg(`REG_STATUS);
			end
			for (int i = 0; i < 6; i++)
			begin
				read_reg(`REG_RESULT);
				read_reg(`REG_IMM);
			end
		end
		stall_max = 0;
		read_reg(`REG_STATUS);
		repeat (4) @(negedge clk);

		assert (sb.size() == 0)
		else
		begin
			errors++;
			$display("%0d results were never read back", sb.size());
		end
		$display("reads %0d, writes %0d, errors %0d", n_reads, n_writes, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
hw/riscv_isa_pkg.sv
hw/axil_pkg.sv
hw/inst_classify.sv
hw/operand_extract.sv
hw/decode_queue.sv
hw/axil_decode_regs.sv
hw/decode_top.sv
bench/decode_tb.sv
